//--- common/ball_link_params.svh
`ifndef BALL_LINK_PARAMS_SVH
`define BALL_LINK_PARAMS_SVH

// 7-bit address of the remote board
// shifted left with R/W = 0 this gives the 8'hAA address byte
`define BALL_LINK_SLAVE_ADDR 7'h55

// payload bytes after the address byte
`define BALL_LINK_DATA_BYTES 5

// clk cycles per quarter of an SCL period
// one SCL bit is four quarters
`define I2C_QUARTER_DIV 4

`endif

//--- common/ball_link_pkg.sv
package ball_link_pkg;

    // one byte as it travels on SDA
    typedef logic [7:0] i2c_byte_t;

    // ball fields handed over by the game logic
    typedef logic [9:0] ball_y_t;
    typedef logic [7:0] ball_vy_t;
    typedef logic [1:0] gravity_t;
    typedef logic [1:0] rand_ball_t;

    typedef struct packed {
        ball_y_t    ball_y;
        ball_vy_t   ball_vy;
        gravity_t   gravity;
        rand_ball_t rand_ball;
        logic       collision;
    } ball_state_t;

    // byte level commands from sequencer to master
    typedef enum logic [1:0] {
        OP_START_WRITE,
        OP_WRITE,
        OP_STOP
    } i2c_op_t;

    typedef struct packed {
        i2c_op_t   op;
        i2c_byte_t data;
    } i2c_cmd_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_ADDR,
        S_DATA,
        S_STOP,
        S_WAIT_STOP
    } seq_state_t;

    typedef enum logic [2:0] {
        M_IDLE,
        M_START,
        M_BIT,
        M_ACK,
        M_STOP
    } master_state_t;

endpackage

//--- i2c_master/i2c_master.sv
`timescale 1ns/1ps
`include "ball_link_params.svh"

module i2c_master (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  ball_link_pkg::i2c_cmd_t cmd,
    input  logic                    sda_in,
    output logic                    cmd_ready,
    output logic                    byte_done,
    output logic                    ack_ok,
    output logic                    scl_oe,
    output logic                    sda_oe
);

    localparam int DIV_W = $clog2(`I2C_QUARTER_DIV + 1);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`I2C_QUARTER_DIV - 1);

    ball_link_pkg::master_state_t state;

    logic [DIV_W-1:0]         div_cnt;
    logic [1:0]               qtr;
    logic [2:0]               bit_cnt;
    ball_link_pkg::i2c_byte_t shift;
    logic                     tick;
    logic                     cmd_taken;
    logic                     bit_step;

    assign cmd_ready = (state == ball_link_pkg::M_IDLE);
    assign cmd_taken = cmd_valid && cmd_ready;
    assign tick      = (div_cnt == DIV_LAST);

    // end of a data bit, shift out the next one
    assign bit_step  = (state == ball_link_pkg::M_BIT) && tick && (qtr == 2'd3);

    // scl_oe/sda_oe keep their value in idle so SCL stays low between bytes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ball_link_pkg::M_IDLE;
            div_cnt   <= '0;
            qtr       <= '0;
            bit_cnt   <= '0;
            byte_done <= 1'b0;
            ack_ok    <= 1'b0;
            scl_oe    <= 1'b0;
            sda_oe    <= 1'b0;
        end else begin
            byte_done <= 1'b0;

            if (state == ball_link_pkg::M_IDLE) begin
                div_cnt <= '0;
                qtr     <= '0;
                bit_cnt <= '0;
                if (cmd_taken) begin
                    case (cmd.op)
                        ball_link_pkg::OP_START_WRITE: begin
                            // SDA falls with SCL high
                            state  <= ball_link_pkg::M_START;
                            scl_oe <= 1'b0;
                            sda_oe <= 1'b1;
                        end
                        ball_link_pkg::OP_WRITE: begin
                            state  <= ball_link_pkg::M_BIT;
                            scl_oe <= 1'b1;
                            sda_oe <= ~cmd.data[7];
                        end
                        default: begin
                            state  <= ball_link_pkg::M_STOP;
                            scl_oe <= 1'b1;
                            sda_oe <= 1'b1;
                        end
                    endcase
                end
            end else if (!tick) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                qtr     <= qtr + 1'b1;

                case (state)
                    ball_link_pkg::M_START: begin
                        if (qtr == 2'd0) begin
                            scl_oe <= 1'b1;
                        end else begin
                            state  <= ball_link_pkg::M_BIT;
                            qtr    <= '0;
                            sda_oe <= ~shift[7];
                        end
                    end

                    ball_link_pkg::M_BIT: begin
                        case (qtr)
                            2'd0: scl_oe <= 1'b0;
                            2'd2: scl_oe <= 1'b1;
                            2'd3: begin
                                if (bit_cnt == 3'd7) begin
                                    // release SDA for the slave ack
                                    state  <= ball_link_pkg::M_ACK;
                                    sda_oe <= 1'b0;
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                    sda_oe  <= ~shift[6];
                                end
                            end
                            default: begin
                            end
                        endcase
                    end

                    ball_link_pkg::M_ACK: begin
                        case (qtr)
                            2'd0: scl_oe <= 1'b0;
                            2'd1: ack_ok <= ~sda_in;
                            2'd2: scl_oe <= 1'b1;
                            default: begin
                                state     <= ball_link_pkg::M_IDLE;
                                byte_done <= 1'b1;
                            end
                        endcase
                    end

                    ball_link_pkg::M_STOP: begin
                        case (qtr)
                            2'd0: scl_oe <= 1'b0;
                            // SDA rises with SCL high
                            2'd1: sda_oe <= 1'b0;
                            default: begin
                                state     <= ball_link_pkg::M_IDLE;
                                byte_done <= 1'b1;
                            end
                        endcase
                    end

                    default: begin
                        state <= ball_link_pkg::M_IDLE;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_taken) begin
            shift <= cmd.data;
        end else if (bit_step) begin
            shift <= {shift[6:0], 1'b0};
        end
    end

endmodule

//--- src/ball_frame_sequencer.sv
`timescale 1ns/1ps
`include "ball_link_params.svh"

module ball_frame_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       send_valid,
    input  ball_link_pkg::ball_state_t ball,
    input  logic                       abort,
    input  logic                       cmd_ready,
    input  logic                       byte_done,
    input  logic                       ack_ok,
    output logic                       send_ready,
    output logic                       cmd_valid,
    output ball_link_pkg::i2c_cmd_t    cmd,
    output logic                       frame_done,
    output logic                       frame_aborted,
    output logic                       frame_nack
);

    localparam int IDX_W = $clog2(`BALL_LINK_DATA_BYTES);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`BALL_LINK_DATA_BYTES - 1);
    localparam ball_link_pkg::i2c_byte_t ADDR_BYTE = {`BALL_LINK_SLAVE_ADDR, 1'b0};

    ball_link_pkg::seq_state_t state, state_next;
    ball_link_pkg::i2c_cmd_t   cmd_next;
    ball_link_pkg::i2c_byte_t  payload [`BALL_LINK_DATA_BYTES];

    logic [IDX_W-1:0] byte_idx, byte_idx_next;
    logic             abort_seen, abort_seen_next;
    logic             nack_seen, nack_seen_next;
    logic             cmd_valid_next;
    logic             load_payload;
    logic             cmd_taken;
    logic             done_next, aborted_next, nack_pulse_next;

    assign send_ready = (state == ball_link_pkg::S_IDLE);
    assign cmd_taken  = cmd_valid && cmd_ready;

    always_comb begin
        state_next      = state;
        cmd_next        = cmd;
        cmd_valid_next  = cmd_valid;
        byte_idx_next   = byte_idx;
        abort_seen_next = abort_seen;
        nack_seen_next  = nack_seen;
        load_payload    = 1'b0;
        done_next       = 1'b0;
        aborted_next    = 1'b0;
        nack_pulse_next = 1'b0;

        // the master is idle whenever we issue, so this is the only drop point
        if (cmd_taken) begin
            cmd_valid_next = 1'b0;
        end

        case (state)
            ball_link_pkg::S_IDLE: begin
                if (send_valid) begin
                    load_payload    = 1'b1;
                    abort_seen_next = 1'b0;
                    nack_seen_next  = 1'b0;
                    byte_idx_next   = '0;
                    cmd_valid_next  = 1'b1;
                    cmd_next.op     = ball_link_pkg::OP_START_WRITE;
                    cmd_next.data   = ADDR_BYTE;
                    state_next      = ball_link_pkg::S_ADDR;
                end
            end

            ball_link_pkg::S_ADDR,
            ball_link_pkg::S_DATA: begin
                abort_seen_next = abort_seen | abort;
                if (byte_done) begin
                    if (!ack_ok) begin
                        nack_seen_next = 1'b1;
                        state_next     = ball_link_pkg::S_STOP;
                    end else if (abort_seen_next ||
                                 (state == ball_link_pkg::S_DATA && byte_idx == LAST_IDX)) begin
                        state_next = ball_link_pkg::S_STOP;
                    end else begin
                        // first payload byte follows the address byte
                        if (state == ball_link_pkg::S_ADDR) begin
                            byte_idx_next = '0;
                        end else begin
                            byte_idx_next = byte_idx + 1'b1;
                        end
                        cmd_valid_next = 1'b1;
                        cmd_next.op    = ball_link_pkg::OP_WRITE;
                        cmd_next.data  = payload[byte_idx_next];
                        state_next     = ball_link_pkg::S_DATA;
                    end

                    if (state_next == ball_link_pkg::S_STOP) begin
                        cmd_valid_next = 1'b1;
                        cmd_next.op    = ball_link_pkg::OP_STOP;
                        cmd_next.data  = '0;
                    end
                end
            end

            ball_link_pkg::S_STOP: begin
                if (cmd_taken) begin
                    state_next = ball_link_pkg::S_WAIT_STOP;
                end
            end

            ball_link_pkg::S_WAIT_STOP: begin
                if (byte_done) begin
                    state_next = ball_link_pkg::S_IDLE;
                    // nack wins if both happened on the same byte
                    if (nack_seen) begin
                        nack_pulse_next = 1'b1;
                    end else if (abort_seen) begin
                        aborted_next = 1'b1;
                    end else begin
                        done_next = 1'b1;
                    end
                end
            end

            default: begin
                state_next = ball_link_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state         <= ball_link_pkg::S_IDLE;
            cmd_valid     <= 1'b0;
            byte_idx      <= '0;
            abort_seen    <= 1'b0;
            nack_seen     <= 1'b0;
            frame_done    <= 1'b0;
            frame_aborted <= 1'b0;
            frame_nack    <= 1'b0;
        end else begin
            state         <= state_next;
            cmd_valid     <= cmd_valid_next;
            byte_idx      <= byte_idx_next;
            abort_seen    <= abort_seen_next;
            nack_seen     <= nack_seen_next;
            frame_done    <= done_next;
            frame_aborted <= aborted_next;
            frame_nack    <= nack_pulse_next;
        end
    end

    always_ff @(posedge clk) begin
        cmd <= cmd_next;
    end

    // frame payload in bus order
    always_ff @(posedge clk) begin
        if (load_payload) begin
            payload[0] <= {ball.ball_y[9:8], 6'b0};
            payload[1] <= ball.ball_y[7:0];
            payload[2] <= ball.ball_vy;
            payload[3] <= {6'b0, ball.gravity};
            payload[4] <= {5'b0, ball.rand_ball, ball.collision};
        end
    end

endmodule

//--- src/ball_link_top.sv
`timescale 1ns/1ps

module ball_link_top (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       send_valid,
    input  ball_link_pkg::ball_state_t ball,
    input  logic                       abort,
    input  logic                       sda_in,
    output logic                       send_ready,
    output logic                       frame_done,
    output logic                       frame_aborted,
    output logic                       frame_nack,
    output logic                       scl_oe,
    output logic                       sda_oe
);

    // sequencer to master command path
    logic                    cmd_valid;
    logic                    cmd_ready;
    ball_link_pkg::i2c_cmd_t cmd;
    logic                    byte_done;
    logic                    ack_ok;

    ball_frame_sequencer u_seq (
        .clk          (clk),
        .reset        (reset),
        .send_valid   (send_valid),
        .ball         (ball),
        .abort        (abort),
        .cmd_ready    (cmd_ready),
        .byte_done    (byte_done),
        .ack_ok       (ack_ok),
        .send_ready   (send_ready),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .frame_done   (frame_done),
        .frame_aborted(frame_aborted),
        .frame_nack   (frame_nack)
    );

    i2c_master u_master (
        .clk      (clk),
        .reset    (reset),
        .cmd_valid(cmd_valid),
        .cmd      (cmd),
        .sda_in   (sda_in),
        .cmd_ready(cmd_ready),
        .byte_done(byte_done),
        .ack_ok   (ack_ok),
        .scl_oe   (scl_oe),
        .sda_oe   (sda_oe)
    );

endmodule

//--- verif/ball_link_sva.sv
`timescale 1ns/1ps

module ball_link_sva (
    input logic                         clk,
    input logic                         reset,
    input ball_link_pkg::master_state_t mstate,
    input logic                         scl_oe,
    input logic                         sda_oe,
    input logic                         cmd_valid,
    input logic                         cmd_ready,
    input ball_link_pkg::i2c_cmd_t      cmd,
    input logic                         send_valid,
    input logic                         send_ready,
    input ball_link_pkg::ball_state_t   ball,
    input logic                         frame_done,
    input logic                         frame_aborted,
    input logic                         frame_nack
);

    // SDA may only move under a high SCL to form START or STOP
    a_sda_scl_high: assert property (@(posedge clk) disable iff (reset)
        (!$past(scl_oe) && !scl_oe && sda_oe != $past(sda_oe)) |->
        (mstate == ball_link_pkg::M_START || mstate == ball_link_pkg::M_STOP))
        else $error("SDA changed while SCL high outside START/STOP");

    a_cmd_stable: assert property (@(posedge clk) disable iff (reset)
        (cmd_valid && !cmd_ready) |=> $stable(cmd))
        else $error("cmd changed under back-pressure");

    a_ball_stable: assert property (@(posedge clk) disable iff (reset)
        (send_valid && !send_ready) |=> $stable(ball))
        else $error("ball changed while waiting for send_ready");

    a_one_pulse: assert property (@(posedge clk) disable iff (reset)
        $onehot0({frame_done, frame_aborted, frame_nack}))
        else $error("more than one completion pulse");

endmodule

bind ball_link_top ball_link_sva u_sva (
    .clk(clk), .reset(reset), .mstate(u_master.state), .scl_oe(scl_oe), .sda_oe(sda_oe),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd), .send_valid(send_valid),
    .send_ready(send_ready), .ball(ball), .frame_done(frame_done),
    .frame_aborted(frame_aborted), .frame_nack(frame_nack)
);

//--- verif/tb_ball_link.sv
`timescale 1ns/1ps
`include "ball_link_params.svh"

module tb_ball_link;

    // one full frame in clk cycles, with slack for the sequencer
    localparam int FRAME_CYCLES = (38 + 36 * `BALL_LINK_DATA_BYTES + 3 + 8) * `I2C_QUARTER_DIV;
    localparam int WAIT_LIMIT = 3 * FRAME_CYCLES;

    logic clk = 1'b0;
    logic reset, send_valid, abort;
    ball_link_pkg::ball_state_t ball;
    logic send_ready, frame_done, frame_aborted, frame_nack, scl_oe, sda_oe;

    // open-drain bus with pull-ups
    logic slave_low, prev_scl, prev_sda, scl, sda;
    assign scl = ~scl_oe;
    assign sda = ~(sda_oe | slave_low);

    int errors = 0;
    int frames = 0;
    int bit_cnt, byte_idx, start_cnt, stop_cnt;
    int nack_at = -1;
    logic [7:0] shreg;
    logic [7:0] rx_q[$];

    ball_link_top UUT (
        .clk(clk), .reset(reset), .send_valid(send_valid), .ball(ball), .abort(abort),
        .sda_in(sda), .send_ready(send_ready), .frame_done(frame_done),
        .frame_aborted(frame_aborted), .frame_nack(frame_nack), .scl_oe(scl_oe), .sda_oe(sda_oe)
    );

    always #2 clk = ~clk;

    // bus slave, sampled on clk
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_scl <= 1'b1;
            prev_sda <= 1'b1;
            slave_low <= 1'b0;
            bit_cnt = 0;
        end else begin
            prev_scl <= scl;
            prev_sda <= sda;
            if (prev_scl && scl && prev_sda && !sda) begin
                start_cnt++;
                bit_cnt = 0;
                byte_idx = 0;
            end else if (prev_scl && scl && !prev_sda && sda) begin
                stop_cnt++;
                bit_cnt = 0;
                slave_low <= 1'b0;
            end else if (!prev_scl && scl && bit_cnt < 8) begin
                shreg = {shreg[6:0], sda};
                bit_cnt++;
                if (bit_cnt == 8) rx_q.push_back(shreg);
            end else if (prev_scl && !scl && bit_cnt == 8) begin
                slave_low <= (byte_idx != nack_at);
                bit_cnt = 9;
            end else if (prev_scl && !scl && bit_cnt == 9) begin
                slave_low <= 1'b0;
                bit_cnt = 0;
                byte_idx++;
            end
        end
    end

    // expected frame byte, address first
    function automatic logic [7:0] exp_byte(ball_link_pkg::ball_state_t b, int i);
        case (i)
            0: return {`BALL_LINK_SLAVE_ADDR, 1'b0};
            1: return {b.ball_y[9:8], 6'b0};
            2: return b.ball_y[7:0];
            3: return b.ball_vy;
            4: return {6'b0, b.gravity};
            default: return {5'b0, b.rand_ball, b.collision};
        endcase
    endfunction

    function automatic ball_link_pkg::ball_state_t random_ball();
        logic [31:0] r;
        r = $urandom;
        return r[$bits(ball_link_pkg::ball_state_t)-1:0];
    endfunction

    task automatic mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        errors++;
        $display("FAILED at %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic fault(string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic send_ball(ball_link_pkg::ball_state_t b);
        int n;
        n = 0;
        @(posedge clk);
        send_valid <= 1'b1;
        ball <= b;
        do begin
            @(posedge clk);
            n++;
        end while (!send_ready && n < WAIT_LIMIT);
        send_valid <= 1'b0;
        if (n >= WAIT_LIMIT) fault("send_valid was never accepted");
    endtask

    // 1 done, 2 aborted, 3 nack, 0 timeout
    task automatic wait_end(output int kind);
        int n;
        kind = 0;
        for (n = 0; n < WAIT_LIMIT && kind == 0; n++) begin
            @(posedge clk);
            if (frame_done) kind = 1;
            else if (frame_aborted) kind = 2;
            else if (frame_nack) kind = 3;
        end
        if (kind == 0) fault("no completion pulse after the frame");
        frames++;
    endtask

    task automatic check_prefix(ball_link_pkg::ball_state_t b, int first, int count);
        for (int i = 0; i < count; i++) begin
            if (rx_q[first + i] !== exp_byte(b, i)) mismatch($sformatf("rx byte %0d", i),
                exp_byte(b, i), rx_q[first + i]);
        end
    endtask

    task automatic check_reset();
        repeat (40) begin
            @(posedge clk);
            if (frame_done || frame_aborted || frame_nack) fault("completion pulse while idle");
        end
        if (send_ready !== 1'b1) mismatch("send_ready", 1, send_ready);
        if (scl !== 1'b1) mismatch("scl", 1, scl);
        if (sda !== 1'b1) mismatch("sda", 1, sda);
    endtask

    task automatic frame_content();
        ball_link_pkg::ball_state_t b;
        int kind, s0, p0;
        repeat (4) begin
            b = random_ball();
            rx_q.delete();
            s0 = start_cnt;
            p0 = stop_cnt;
            send_ball(b);
            wait_end(kind);
            if (kind != 1) mismatch("completion kind", 1, kind);
            if (rx_q.size() != 6) mismatch("rx byte count", 6, rx_q.size());
            else check_prefix(b, 0, 6);
            if (start_cnt - s0 != 1) mismatch("start count", 1, start_cnt - s0);
            if (stop_cnt - p0 != 1) mismatch("stop count", 1, stop_cnt - p0);
        end
    endtask

    task automatic back_pressure();
        ball_link_pkg::ball_state_t a, b;
        int kind, n;
        a = random_ball();
        b = random_ball();
        rx_q.delete();
        send_ball(a);
        send_valid <= 1'b1;
        ball <= b;
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!send_ready && n < WAIT_LIMIT);
        // first frame must finish on the edge that frees send_ready
        if (!frame_done) fault("send_ready rose before the first frame completed");
        frames++;
        send_valid <= 1'b0;
        wait_end(kind);
        if (kind != 1) mismatch("completion kind", 1, kind);
        if (rx_q.size() != 12) mismatch("rx byte count", 12, rx_q.size());
        else begin
            check_prefix(a, 0, 6);
            check_prefix(b, 6, 6);
        end
    endtask

    task automatic abort_frame();
        ball_link_pkg::ball_state_t b;
        int kind, p0, n;
        b = random_ball();
        rx_q.delete();
        p0 = stop_cnt;
        send_ball(b);
        n = 0;
        while (!(byte_idx == 2 && bit_cnt > 0 && bit_cnt < 8) && n < WAIT_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (n >= WAIT_LIMIT) fault("third byte never started on the bus");
        abort <= 1'b1;
        wait_end(kind);
        abort <= 1'b0;
        if (kind != 2) mismatch("completion kind", 2, kind);
        // the byte in flight still completes, nothing after it
        if (rx_q.size() != 3) mismatch("rx byte count", 3, rx_q.size());
        else check_prefix(b, 0, rx_q.size());
        if (stop_cnt - p0 != 1) mismatch("stop count", 1, stop_cnt - p0);
    endtask

    task automatic nack_frame(int k);
        ball_link_pkg::ball_state_t b;
        int kind, p0;
        b = random_ball();
        rx_q.delete();
        p0 = stop_cnt;
        nack_at = k;
        send_ball(b);
        wait_end(kind);
        nack_at = -1;
        if (kind != 3) mismatch("completion kind", 3, kind);
        if (rx_q.size() != k + 1) mismatch("rx byte count", k + 1, rx_q.size());
        else check_prefix(b, 0, k + 1);
        if (stop_cnt - p0 != 1) mismatch("stop count", 1, stop_cnt - p0);
        frame_content();
    endtask

    initial begin
        void'($urandom(32'ha483_0163));
        reset = 1'b1;
        send_valid = 1'b0;
        abort = 1'b0;
        ball = '0;
        start_cnt = 0;
        stop_cnt = 0;
        byte_idx = 0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        check_reset();
        frame_content();
        back_pressure();
        abort_frame();
        nack_frame(0);
        nack_frame(3);
        repeat (10) @(posedge clk);
        $display("frames: %0d  errors: %0d", frames, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    // 17 frames of about 3.7 us each fit well inside 200 us
    initial begin
        #200_000;
        $display("watchdog expired before the tests finished");
        $display("test failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+common
common/ball_link_pkg.sv
i2c_master/i2c_master.sv
src/ball_frame_sequencer.sv
src/ball_link_top.sv
verif/ball_link_sva.sv
verif/tb_ball_link.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and decide by searching the log for the pass line.
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_ball_link -o sim_tb \
    > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
